//--- include/ecc_mem_settings.svh
// width and depth macros for the SECDED memory port
`ifndef ECC_MEM_SETTINGS_SVH
`define ECC_MEM_SETTINGS_SVH

// payload word width
`define ECC_DATA_W 32

// hsiao check field width for a 32-bit word
`define ECC_CHECK_W 7

// word address width
`define ECC_ADDR_W 6

// number of stored words, matches the address width
`define ECC_MEM_DEPTH 64

`endif

//--- verilog/ecc_mem_pkg.sv
// shared types for the SECDED memory port
// also holds the hsiao column table used by encoder and decoder
`include "ecc_mem_settings.svh"

package ecc_mem_pkg;

  typedef logic [`ECC_DATA_W-1:0] data_t;
  typedef logic [`ECC_CHECK_W-1:0] check_t;
  // check field sits above the data bits
  typedef logic [`ECC_CHECK_W+`ECC_DATA_W-1:0] code_t;
  typedef logic [`ECC_ADDR_W-1:0] addr_t;
  typedef logic [`ECC_CHECK_W-1:0] syndrome_t;
  // bit 0 corrected single error, bit 1 uncorrectable
  typedef logic [1:0] err_t;
  typedef logic [15:0] cnt_t;

  typedef enum logic {
    IDLE,
    WRITE_BUSY
  } sram_state_e;

  // weight-3 columns in lexicographic order, data bit 0 at the right end
  localparam check_t [`ECC_DATA_W-1:0] HSIAO_COL = {
    7'h38, 7'h64, 7'h54, 7'h34, 7'h4c, 7'h2c, 7'h1c, 7'h62,
    7'h52, 7'h32, 7'h4a, 7'h2a, 7'h1a, 7'h46, 7'h26, 7'h16,
    7'h0e, 7'h61, 7'h51, 7'h31, 7'h49, 7'h29, 7'h19, 7'h45,
    7'h25, 7'h15, 7'h0d, 7'h43, 7'h23, 7'h13, 7'h0b, 7'h07
  };

endpackage

//--- verilog/secded_39_32_enc.sv
// hsiao SECDED encoder, 32 data bits to 7 check bits
// purely combinational
`include "ecc_mem_settings.svh"

module secded_39_32_enc (
  input  ecc_mem_pkg::data_t  data_i,
  output ecc_mem_pkg::check_t check_o
);

  import ecc_mem_pkg::*;

  // row view of the parity matrix
  // check bit i covers every data bit whose column has bit i set
  always_comb begin
    check_o = '0;
    for (int i = 0; i < `ECC_CHECK_W; i++) begin
      for (int j = 0; j < `ECC_DATA_W; j++) begin
        // and-mask the data bit with the column entry, then fold into parity
        check_o[i] = check_o[i] ^ (data_i[j] & HSIAO_COL[j][i]);
      end
    end
  end

  // all data columns are weight 3, check columns weight 1
  // so any single flip gives an odd, distinct syndrome
  // and any double flip gives an even, nonzero one

endmodule

//--- verilog/secded_39_32_dec.sv
// hsiao SECDED decoder for a 39-bit codeword
// syndrome, single-bit correction and error classification
`include "ecc_mem_settings.svh"

module secded_39_32_dec (
  input  ecc_mem_pkg::code_t     code_i,
  output ecc_mem_pkg::data_t     data_o,
  output ecc_mem_pkg::syndrome_t syndrome_o,
  output ecc_mem_pkg::err_t      err_o
);

  import ecc_mem_pkg::*;

  data_t  rd_data;
  check_t rd_check;
  // syndrome matches one of the data columns
  logic   data_hit;
  // syndrome is one-hot, so the flip is in the check field
  logic   check_hit;

  assign rd_data  = code_i[`ECC_DATA_W-1:0];
  assign rd_check = code_i[`ECC_CHECK_W+`ECC_DATA_W-1:`ECC_DATA_W];

  // column view of the same matrix
  // start from the stored check and add the column of every set data bit
  always_comb begin
    syndrome_o = rd_check;
    for (int j = 0; j < `ECC_DATA_W; j++) begin
      if (rd_data[j]) begin
        syndrome_o = syndrome_o ^ HSIAO_COL[j];
      end
    end
  end

  // flip the one data bit whose column equals the syndrome
  always_comb begin
    data_o   = rd_data;
    data_hit = 1'b0;
    for (int j = 0; j < `ECC_DATA_W; j++) begin
      if (syndrome_o == HSIAO_COL[j]) begin
        data_o[j] = ~rd_data[j];
        data_hit  = 1'b1;
      end
    end
  end

  assign check_hit = $onehot(syndrome_o);

  // zero syndrome is clean
  // a known column is a corrected single error
  // even weight or an unused odd pattern cannot be corrected
  always_comb begin
    if (syndrome_o == '0) begin
      err_o = 2'b00;
    end else if (data_hit || check_hit) begin
      err_o = 2'b01;
    end else begin
      err_o = 2'b10;
    end
  end

endmodule

//--- verilog/mem_ecc_bridge.sv
// ECC bridge between the requester bus and the 39-bit SRAM
// encodes and injects on writes, decodes on the read return path
module mem_ecc_bridge (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // requester side
  input  logic                   req_i,
  input  logic                   we_i,
  input  ecc_mem_pkg::addr_t     addr_i,
  input  ecc_mem_pkg::data_t     wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output ecc_mem_pkg::data_t     rdata_o,
  output ecc_mem_pkg::syndrome_t syndrome_o,
  output ecc_mem_pkg::err_t      err_o,
  // sram side
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output ecc_mem_pkg::addr_t     mem_addr_o,
  output ecc_mem_pkg::code_t     mem_wcode_o,
  input  logic                   mem_gnt_i,
  input  logic                   mem_rvalid_i,
  input  ecc_mem_pkg::code_t     mem_rcode_i,
  // fault injection from the register block
  input  ecc_mem_pkg::code_t     inject_mask_i,
  output logic                   inject_used_o
);

  import ecc_mem_pkg::*;

  check_t    wr_check;
  syndrome_t dec_syndrome;
  err_t      dec_err;

  // request side goes straight through
  assign mem_req_o  = req_i;
  assign mem_we_o   = we_i;
  assign mem_addr_o = addr_i;
  assign gnt_o      = mem_gnt_i;

  secded_39_32_enc u_enc (
    .data_i  (wdata_i),
    .check_o (wr_check)
  );

  // mask flips stored bits, check field included
  assign mem_wcode_o = {wr_check, wdata_i} ^ inject_mask_i;

  // one-shot: tells the register block the mask went out
  assign inject_used_o = req_i && we_i && mem_gnt_i && (inject_mask_i != '0);

  secded_39_32_dec u_dec (
    .code_i     (mem_rcode_i),
    .data_o     (rdata_o),
    .syndrome_o (dec_syndrome),
    .err_o      (dec_err)
  );

  assign rvalid_o = mem_rvalid_i;
  // status only means something alongside rvalid
  assign syndrome_o = mem_rvalid_i ? dec_syndrome : '0;
  assign err_o      = mem_rvalid_i ? dec_err : '0;

  // read data must trace back to a read granted one cycle earlier
  a_rvalid_after_read: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_rvalid_i |-> $past(req_i && mem_gnt_i && !we_i));

endmodule

//--- verilog/ecc_sram.sv
// behavioral 39-bit SRAM with a req/gnt front end
// one-cycle read and a write committed in the following busy cycle
`include "ecc_mem_settings.svh"

module ecc_sram (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               req_i,
  input  logic               we_i,
  input  ecc_mem_pkg::addr_t addr_i,
  input  ecc_mem_pkg::code_t wcode_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output ecc_mem_pkg::code_t rcode_o
);

  import ecc_mem_pkg::*;

  code_t       mem_q [`ECC_MEM_DEPTH];
  sram_state_e state_q;
  // write held for commit in the busy cycle
  addr_t       wr_addr_q;
  code_t       wr_code_q;

  // only accept new work when idle
  assign gnt_o = (state_q == IDLE);

  // front-end FSM and read return
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= IDLE;
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i && gnt_o && !we_i;
      if (state_q == IDLE && req_i && we_i) begin
        state_q <= WRITE_BUSY;
      end else begin
        state_q <= IDLE;
      end
    end
  end

  // array and captured payload
  always_ff @(posedge clk_i) begin
    if (req_i && gnt_o) begin
      if (we_i) begin
        wr_addr_q <= addr_i;
        wr_code_q <= wcode_i;
      end else begin
        rcode_o <= mem_q[addr_i];
      end
    end
    // second write cycle commits the word
    if (state_q == WRITE_BUSY) begin
      mem_q[wr_addr_q] <= wr_code_q;
    end
  end

  // a request refused in the busy cycle is held unchanged and granted next
  a_busy_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_i && !gnt_o) |=> req_i && gnt_o && $stable(we_i) && $stable(addr_i));

endmodule

//--- verilog/ecc_err_regs.sv
// configuration and error log with the one-shot injection mask
// saturating corrected and uncorrectable counters and the last syndrome
`include "ecc_mem_settings.svh"

module ecc_err_regs (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // config port with a single-cycle write strobe
  input  logic                   cfg_we_i,
  input  logic [1:0]             cfg_addr_i,
  input  ecc_mem_pkg::data_t     cfg_wdata_i,
  output ecc_mem_pkg::data_t     cfg_rdata_o,
  // injection toward the bridge
  output ecc_mem_pkg::code_t     inject_mask_o,
  input  logic                   inject_used_i,
  // read status from the bridge
  input  logic                   rvalid_i,
  input  ecc_mem_pkg::err_t      err_i,
  input  ecc_mem_pkg::syndrome_t syndrome_i
);

  import ecc_mem_pkg::*;

  data_t     mask_data_q;
  code_t     mask_q;
  cnt_t      corr_cnt_q;
  cnt_t      unc_cnt_q;
  syndrome_t last_syn_q;

  assign inject_mask_o = mask_q;

  // mask staging and arming
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask_data_q <= '0;
      mask_q      <= '0;
    end else begin
      if (cfg_we_i && cfg_addr_i == 2'd0) begin
        mask_data_q <= cfg_wdata_i;
      end
      // a new arm in the same cycle wins over dropping the used mask
      if (cfg_we_i && cfg_addr_i == 2'd1) begin
        mask_q <= {cfg_wdata_i[`ECC_CHECK_W-1:0], mask_data_q};
      end else if (inject_used_i) begin
        mask_q <= '0;
      end
    end
  end

  // clear has priority over counting
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      corr_cnt_q <= '0;
      unc_cnt_q  <= '0;
      last_syn_q <= '0;
    end else begin
      if (cfg_we_i && cfg_addr_i == 2'd2) begin
        corr_cnt_q <= '0;
        unc_cnt_q  <= '0;
      end else if (rvalid_i) begin
        // counters stick at all ones
        if (err_i[0] && corr_cnt_q != '1) begin
          corr_cnt_q <= corr_cnt_q + 1'b1;
        end
        if (err_i[1] && unc_cnt_q != '1) begin
          unc_cnt_q <= unc_cnt_q + 1'b1;
        end
      end
      if (rvalid_i && err_i != '0) begin
        last_syn_q <= syndrome_i;
      end
    end
  end

  // readback follows the address with no delay
  always_comb begin
    case (cfg_addr_i)
      2'd0:    cfg_rdata_o = mask_data_q;
      2'd1:    cfg_rdata_o = {{(`ECC_DATA_W-`ECC_CHECK_W){1'b0}},
                              mask_q[`ECC_CHECK_W+`ECC_DATA_W-1:`ECC_DATA_W]};
      2'd2:    cfg_rdata_o = {16'h0000, corr_cnt_q};
      default: cfg_rdata_o = {unc_cnt_q, {(16-`ECC_CHECK_W){1'b0}}, last_syn_q};
    endcase
  end

endmodule

//--- verilog/ecc_mem_top.sv
// top level of the SECDED memory port
// bridge, SRAM and config/error-log block
module ecc_mem_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // memory bus
  input  logic                   req_i,
  input  logic                   we_i,
  input  ecc_mem_pkg::addr_t     addr_i,
  input  ecc_mem_pkg::data_t     wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output ecc_mem_pkg::data_t     rdata_o,
  output ecc_mem_pkg::syndrome_t syndrome_o,
  output ecc_mem_pkg::err_t      err_o,
  // config port
  input  logic                   cfg_we_i,
  input  logic [1:0]             cfg_addr_i,
  input  ecc_mem_pkg::data_t     cfg_wdata_i,
  output ecc_mem_pkg::data_t     cfg_rdata_o
);

  import ecc_mem_pkg::*;

  // bridge to SRAM
  logic  mem_req;
  logic  mem_we;
  addr_t mem_addr;
  code_t mem_wcode;
  logic  mem_gnt;
  logic  mem_rvalid;
  code_t mem_rcode;
  // register block to bridge
  code_t inject_mask;
  logic  inject_used;

  mem_ecc_bridge u_bridge (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .gnt_o         (gnt_o),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o),
    .syndrome_o    (syndrome_o),
    .err_o         (err_o),
    .mem_req_o     (mem_req),
    .mem_we_o      (mem_we),
    .mem_addr_o    (mem_addr),
    .mem_wcode_o   (mem_wcode),
    .mem_gnt_i     (mem_gnt),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rcode_i   (mem_rcode),
    .inject_mask_i (inject_mask),
    .inject_used_o (inject_used)
  );

  ecc_sram u_sram (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wcode_i  (mem_wcode),
    .gnt_o    (mem_gnt),
    .rvalid_o (mem_rvalid),
    .rcode_o  (mem_rcode)
  );

  // logs what the bridge returns to the requester
  ecc_err_regs u_regs (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .cfg_rdata_o   (cfg_rdata_o),
    .inject_mask_o (inject_mask),
    .inject_used_i (inject_used),
    .rvalid_i      (rvalid_o),
    .err_i         (err_o),
    .syndrome_i    (syndrome_o)
  );

endmodule

//--- dv/ecc_mem_tb.sv
// testbench for the SECDED memory port
// replays the trace on the bus and config ports, checks every response
module ecc_mem_tb;

  import ecc_mem_pkg::*;

  localparam int    CLK_PERIOD    = 20;
  localparam int    RESET_CYCLES  = 8;
  localparam int    DRIVE_DELAY   = 2;
  localparam int    CYCLES_PER_OP = 20;
  localparam string TRACE_FILE    = "dv/ecc_mem_trace.txt";

  logic       clk_i;
  logic       rst_i;
  logic       req_i;
  logic       we_i;
  addr_t      addr_i;
  data_t      wdata_i;
  logic       gnt_o;
  logic       rvalid_o;
  data_t      rdata_o;
  syndrome_t  syndrome_o;
  err_t       err_o;
  logic       cfg_we_i;
  logic [1:0] cfg_addr_i;
  data_t      cfg_wdata_i;
  data_t      cfg_rdata_o;

  // one entry per trace line
  string       op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_data_q[$];
  logic [31:0] exp_err_q[$];
  logic [31:0] exp_syn_q[$];

  int   cycle_cnt   = 0;
  int   cycle_limit = 0;
  // write granted one and two negedges ago
  logic wr_busy_1;
  logic wr_busy_2;

  ecc_mem_top dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .gnt_o       (gnt_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .syndrome_o  (syndrome_o),
    .err_o       (err_o),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // limit grows with the number of trace lines
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      stop_run($sformatf("timeout after %0d cycles waiting on the DUT", cycle_cnt));
    end
  end

  // grant must drop for exactly the cycle after a granted write
  always @(negedge clk_i) begin
    if (rst_i) begin
      wr_busy_1 = 1'b0;
      wr_busy_2 = 1'b0;
    end else begin
      if (wr_busy_1) begin
        assert (gnt_o === 1'b0) else report_mismatch("gnt_o", 32'(gnt_o), 32'h0);
      end
      if (wr_busy_2) begin
        assert (gnt_o === 1'b1) else report_mismatch("gnt_o", 32'(gnt_o), 32'h1);
      end
      wr_busy_2 = wr_busy_1;
      wr_busy_1 = req_i && we_i && gnt_o;
    end
  end

  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] ed;
    logic [31:0] ee;
    logic [31:0] es;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      stop_run("could not open the trace file");
    end
    while ($fgets(line, fd) != 0) begin
      // comment and blank lines carry no operation
      if (line.len() == 0 || line.substr(0, 0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %h %h %h", op, a, d, ed, ee, es);
      if (n <= 0) begin
        continue;
      end
      if (n != 6) begin
        stop_run($sformatf("trace line has %0d fields instead of 6", n));
      end
      op_q.push_back(op);
      addr_q.push_back(a);
      data_q.push_back(d);
      exp_data_q.push_back(ed);
      exp_err_q.push_back(ee);
      exp_syn_q.push_back(es);
    end
    $fclose(fd);
    if (op_q.size() == 0) begin
      stop_run("trace file holds no operations");
    end
    cycle_limit = RESET_CYCLES + CYCLES_PER_OP * op_q.size();
  endtask

  // sample at negedge, the handshake completes at the next rising edge
  task automatic wait_grant();
    @(negedge clk_i);
    while (gnt_o !== 1'b1) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  task automatic write_word(input addr_t a, input data_t d);
    req_i   = 1'b1;
    we_i    = 1'b1;
    addr_i  = a;
    wdata_i = d;
    wait_grant();
    #(DRIVE_DELAY);
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic read_word(input addr_t a, input data_t exp_d, input err_t exp_e,
                           input syndrome_t exp_s);
    req_i  = 1'b1;
    we_i   = 1'b0;
    addr_i = a;
    wait_grant();
    #(DRIVE_DELAY);
    req_i = 1'b0;
    @(negedge clk_i);
    while (rvalid_o !== 1'b1) begin
      @(negedge clk_i);
    end
    assert (rdata_o === exp_d) else report_mismatch("rdata_o", rdata_o, exp_d);
    assert (err_o === exp_e) else report_mismatch("err_o", 32'(err_o), 32'(exp_e));
    assert (syndrome_o === exp_s)
      else report_mismatch("syndrome_o", 32'(syndrome_o), 32'(exp_s));
    @(posedge clk_i);
    #(DRIVE_DELAY);
  endtask

  task automatic write_cfg(input logic [1:0] a, input data_t d);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = a;
    cfg_wdata_i = d;
    @(posedge clk_i);
    #(DRIVE_DELAY);
    cfg_we_i = 1'b0;
  endtask

  // readback is combinational, so one negedge sample is enough
  task automatic read_cfg(input logic [1:0] a, input data_t exp_d);
    cfg_addr_i = a;
    @(negedge clk_i);
    assert (cfg_rdata_o === exp_d) else report_mismatch("cfg_rdata_o", cfg_rdata_o, exp_d);
    @(posedge clk_i);
    #(DRIVE_DELAY);
  endtask

  task automatic check_reset_state();
    @(negedge clk_i);
    assert (gnt_o === 1'b1) else report_mismatch("gnt_o", 32'(gnt_o), 32'h1);
    assert (rvalid_o === 1'b0) else report_mismatch("rvalid_o", 32'(rvalid_o), 32'h0);
    assert (err_o === 2'b00) else report_mismatch("err_o", 32'(err_o), 32'h0);
    @(posedge clk_i);
    #(DRIVE_DELAY);
  endtask

  initial begin
    rst_i       = 1'b1;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = 2'd0;
    cfg_wdata_i = '0;
    load_trace();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY);
    rst_i = 1'b0;
    check_reset_state();
    // every task returns just after a rising edge, so ops run back to back
    for (int i = 0; i < op_q.size(); i++) begin
      if (op_q[i] == "wr") begin
        write_word(addr_t'(addr_q[i]), data_q[i]);
      end else if (op_q[i] == "rd") begin
        read_word(addr_t'(addr_q[i]), exp_data_q[i], err_t'(exp_err_q[i]),
                  syndrome_t'(exp_syn_q[i]));
      end else if (op_q[i] == "cw") begin
        write_cfg(2'(addr_q[i]), data_q[i]);
      end else if (op_q[i] == "cr") begin
        read_cfg(2'(addr_q[i]), exp_data_q[i]);
      end else begin
        stop_run($sformatf("unknown operation %s in the trace", op_q[i]));
      end
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- list.f
+incdir+include
verilog/ecc_mem_pkg.sv
verilog/secded_39_32_enc.sv
verilog/secded_39_32_dec.sv
verilog/mem_ecc_bridge.sv
verilog/ecc_sram.sv
verilog/ecc_err_regs.sv
verilog/ecc_mem_top.sv
dv/ecc_mem_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = ecc_mem_tb
FILELIST = list.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- dv/ecc_mem_trace.txt
# columns: op addr wdata exp_rdata exp_err exp_syndrome, all hex
# wr rd go to the memory bus, cw cr to the config port with addr as the register
cr 2 00000000 00000000 0 00
cr 3 00000000 00000000 0 00
# clean writes then reads
wr 00 00000000 00000000 0 00
wr 01 a5a5a5a5 00000000 0 00
wr 3f deadbeef 00000000 0 00
wr 15 12345678 00000000 0 00
rd 00 00000000 00000000 0 00
rd 01 00000000 a5a5a5a5 0 00
rd 3f 00000000 deadbeef 0 00
rd 15 00000000 12345678 0 00
# data bit 5 flipped once, its encoder column is 0d
cw 0 00000020 00000000 0 00
cw 1 00000000 00000000 0 00
wr 04 cafef00d 00000000 0 00
rd 04 00000000 cafef00d 1 0d
cr 2 00000000 00000001 0 00
cr 3 00000000 0000000d 0 00
# check bit 2 flipped once, mask clears after the write
cw 0 00000000 00000000 0 00
cw 1 00000004 00000000 0 00
cr 1 00000000 00000004 0 00
wr 05 0f0f0f0f 00000000 0 00
cr 1 00000000 00000000 0 00
rd 05 00000000 0f0f0f0f 1 04
cr 2 00000000 00000002 0 00
# data bits 0 and 1 flipped, columns 07 and 0b give 0c
cw 0 00000003 00000000 0 00
cw 1 00000000 00000000 0 00
wr 06 ffff0000 00000000 0 00
rd 06 00000000 ffff0003 2 0c
cr 3 00000000 0001000c 0 00
# one-shot mask, the rewrite reads back clean
wr 06 ffff0000 00000000 0 00
rd 06 00000000 ffff0000 0 00
# read right behind a write waits out the busy cycle
wr 2a 13579bdf 00000000 0 00
rd 2a 00000000 13579bdf 0 00
wr 2b 2468ace0 00000000 0 00
rd 2b 00000000 2468ace0 0 00
# counter clear keeps the last syndrome
cw 2 00000000 00000000 0 00
cr 2 00000000 00000000 0 00
cr 3 00000000 0000000c 0 00
